/* common/lcd_consts.svh */
//########################################
// shared constants for the LCD front panel
// screen size, bus slot length, special
// character codes and the BPM display rule
//########################################
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// screen geometry, 4 lines of 16 characters
`define LCD_CHARS 64
// characters per DDRAM row (lines 1+3, then 2+4)
`define LCD_HALF_CHARS 32

// clocks per bus slot, must be even and at least 4
`define LCD_E_PERIOD 16

// special character codes from the HD44780 ROM
`define LCD_CURSOR_CHAR 8'h10
`define LCD_BLOCK_CHAR 8'hDB
`define LCD_SPACE 8'h20

// bpm shown = base + step * rate
`define BPM_BASE 30
`define BPM_STEP 5
// rates above this show the base value
`define RATE_MAX 154

`endif

/* common/lcd_pkg.sv */
//########################################
// LCD bus word, sequencer states and the
// HD44780 command opcodes used per frame
//########################################
package lcd_pkg;

    // one character code or command byte
    typedef logic [7:0] char_t;

    // write-only bus word, held for a whole slot
    typedef struct packed {
        logic  rs;     // 0 command, 1 data
        logic  rw;     // always write
        char_t data;
    } lcd_bus_t;

    // command opcodes
    typedef enum logic [7:0] {
        wake_set     = 8'h30,  // 8-bit interface wake-up
        clear        = 8'h01,
        home         = 8'h02,
        entry_mode   = 8'h06,  // increment, no shift
        display_on   = 8'h0E,  // display and cursor on
        cursor_shift = 8'h14,
        function_set = 8'h3C,  // 8-bit, 2 lines, 5x10
        line2_addr   = 8'hC0   // set DDRAM address 0x40
    } lcd_cmd_t;

    // sequencer states, one bus word each
    // except the two write states
    typedef enum logic [3:0] {
        st_wake1,
        st_wake2,
        st_wake3,
        st_clear,
        st_home,
        st_entry,
        st_display,
        st_shift,
        st_func,
        st_write_upper,
        st_jump_lower,
        st_write_lower,
        st_return_home
    } lcd_state_t;

endpackage

/* common/panel_pkg.sv */
//########################################
// front-panel settings of the LFO: which
// row is selected, wave shape, depth, rate
//########################################
package panel_pkg;

    // selected parameter row, 3 falls back to rate
    typedef enum logic [1:0] {
        sel_rate     = 2'd0,
        sel_wave     = 2'd1,
        sel_depth    = 2'd2,
        sel_rate_alt = 2'd3
    } param_sel_t;

    // wave shapes, codes 6 and 7 unused
    typedef enum logic [2:0] {
        sine        = 3'd0,
        square      = 3'd1,
        triangle    = 3'd2,
        ramp_up     = 3'd3,
        ramp_down   = 3'd4,
        sample_hold = 3'd5
    } wave_t;

    // full panel state, 16 bits
    typedef struct packed {
        param_sel_t  sel;
        wave_t       wave;
        logic [2:0]  depth;  // 0..4 valid
        logic [7:0]  rate;   // 0..154 valid
    } panel_t;

endpackage

/* dv/lcd_panel_assertions.sv */
//########################################
// bus protocol checks bound into the LCD
// panel top level
//########################################
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_panel_assertions (
    input logic              E,
    input logic              rst,
    input lcd_pkg::lcd_bus_t bus,
    input logic              lcd_en
);

    localparam logic [7:0] HALF = 8'(`LCD_E_PERIOD / 2);

    // clocks with lcd_en high in the current pulse
    logic [7:0] high_cnt;

    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            high_cnt <= '0;
        end else if (lcd_en) begin
            high_cnt <= high_cnt + 8'd1;
        end else begin
            high_cnt <= '0;
        end
    end

    // write-only bus
    rw_low: assert property (@(posedge E) disable iff (!rst) !bus.rw)
        else $error("rw went high");

    // new word only together with the enable rise
    bus_stable: assert property (@(posedge E) disable iff (!rst) $changed(bus) |-> $rose(lcd_en))
        else $error("bus changed outside the enable rise");

    en_width: assert property (@(posedge E) disable iff (!rst) $fell(lcd_en) |-> high_cnt == HALF)
        else $error("lcd_en pulse has the wrong width");

    en_max: assert property (@(posedge E) disable iff (!rst) high_cnt <= HALF)
        else $error("lcd_en high too long");

endmodule

bind lcd_panel_top lcd_panel_assertions lcd_panel_assertions_i (
    .E      (E),
    .rst    (rst),
    .bus    (bus),
    .lcd_en (lcd_en)
);

/* dv/lcd_panel_tb.sv */
//########################################
// testbench for the LCD front panel, runs
// 12 frames with random panel settings and
// checks every bus word against a model
//########################################
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_panel_tb;

    // edge waits give up after a few slots
    localparam int TIMEOUT = 4 * `LCD_E_PERIOD;
    localparam int FRAME_WORDS = 75;
    localparam int FRAMES = 12;

    logic              E;
    logic              rst;
    panel_pkg::panel_t panel;
    lcd_pkg::lcd_bus_t bus;
    logic              lcd_en;

    int                seed;
    logic [9:0]        sampled;
    panel_pkg::panel_t next_panel;
    logic [7:0]        screen_exp [0:`LCD_CHARS-1];
    logic [9:0]        frame_exp [0:FRAME_WORDS-1];

    lcd_panel_top lcd_panel_top_i (
        .E      (E),
        .rst    (rst),
        .panel  (panel),
        .bus    (bus),
        .lcd_en (lcd_en)
    );

    initial begin
        E = 1'b0;
        forever #5 E = ~E;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int idx,
                               input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, word %0d, got %h, expected %h",
                     $time, what, idx, got, exp);
            abort_run();
        end
    endtask

    // one bus slot, returns right after lcd_en falls
    task automatic wait_word();
        int n;
        n = 0;
        while (lcd_en !== 1'b1 && n < TIMEOUT) begin
            @(negedge E);
            n++;
        end
        if (lcd_en !== 1'b1) begin
            $display("error at %0t: lcd_en stopped toggling, it never rose", $time);
            abort_run();
        end
        n = 0;
        while (lcd_en === 1'b1 && n < TIMEOUT) begin
            @(negedge E);
            n++;
        end
        if (lcd_en === 1'b1) begin
            $display("error at %0t: lcd_en stopped toggling, it stayed high", $time);
            abort_run();
        end
    endtask

    task automatic put_text(input int pos, input string s);
        for (int i = 0; i < s.len(); i++) begin
            screen_exp[pos + i] = s[i];
        end
    endtask

    // expected 75 words of a frame from the panel rules
    task automatic build_frame(input panel_pkg::panel_t p);
        int bpm;
        int blocks;
        string name;
        for (int i = 0; i < `LCD_CHARS; i++) begin
            screen_exp[i] = `LCD_SPACE;
        end
        put_text(0, " LFO GENERATOR  ");
        put_text(17, " RATE: ");
        put_text(27, " BPM ");
        put_text(33, " WAVE: ");
        put_text(49, " DEPTH: ");
        // cursor row, 0 and 3 both mean rate
        case (p.sel)
            panel_pkg::sel_wave:  screen_exp[32] = `LCD_CURSOR_CHAR;
            panel_pkg::sel_depth: screen_exp[48] = `LCD_CURSOR_CHAR;
            default:              screen_exp[16] = `LCD_CURSOR_CHAR;
        endcase
        case (p.wave)
            panel_pkg::square:      name = "SQUARE";
            panel_pkg::triangle:    name = "TRIANGLE";
            panel_pkg::ramp_up:     name = "RAMP UP";
            panel_pkg::ramp_down:   name = "RAMPDOWN";
            panel_pkg::sample_hold: name = "S & H";
            default:                name = "SINE";
        endcase
        put_text(40, name);
        // d+1 blocks, out of range depth gives one
        blocks = (p.depth <= 3'd4) ? int'(p.depth) + 1 : 1;
        for (int i = 0; i < blocks; i++) begin
            screen_exp[57 + i] = `LCD_BLOCK_CHAR;
        end
        bpm = (int'(p.rate) <= `RATE_MAX) ? `BPM_BASE + `BPM_STEP * int'(p.rate) : `BPM_BASE;
        screen_exp[24] = (bpm < 100) ? `LCD_SPACE : 8'(48 + bpm / 100);
        screen_exp[25] = 8'(48 + (bpm / 10) % 10);
        screen_exp[26] = 8'(48 + bpm % 10);
        // setup commands, rs low
        frame_exp[0] = {2'b00, 8'h30};
        frame_exp[1] = {2'b00, 8'h30};
        frame_exp[2] = {2'b00, 8'h30};
        frame_exp[3] = {2'b00, 8'h01};
        frame_exp[4] = {2'b00, 8'h02};
        frame_exp[5] = {2'b00, 8'h06};
        frame_exp[6] = {2'b00, 8'h0E};
        frame_exp[7] = {2'b00, 8'h14};
        frame_exp[8] = {2'b00, 8'h3C};
        for (int i = 0; i < `LCD_HALF_CHARS; i++) begin
            frame_exp[9 + i]  = {2'b10, screen_exp[i]};
            frame_exp[42 + i] = {2'b10, screen_exp[`LCD_HALF_CHARS + i]};
        end
        frame_exp[41] = {2'b00, 8'hC0};
        frame_exp[74] = {2'b00, 8'h02};
    endtask

    // walk=1 steps sel, wave and depth through all codes
    task automatic draw_panel(input int frame_no, input logic walk,
                              output panel_pkg::panel_t p);
        logic [1:0] sel;
        logic [2:0] wave;
        logic [2:0] depth;
        logic [7:0] rate;
        sel   = 2'($random(seed));
        wave  = 3'($random(seed));
        depth = 3'($random(seed));
        rate  = 8'($random(seed));
        if (walk) begin
            sel   = 2'(frame_no);
            wave  = 3'(frame_no);
            depth = 3'(frame_no * 3);
            // rate corners around the bpm limit
            case (frame_no)
                2: rate = 8'd154;
                3: rate = 8'd155;
                5: rate = 8'd255;
                6: rate = 8'd0;
                default: ;
            endcase
        end
        p = panel_pkg::panel_t'({sel, wave, depth, rate});
    endtask

    initial begin
        seed     = 32'h6195bdb8;
        rst      = 1'b0;
        panel    = '0;
        build_frame('0);
        @(posedge E);
        @(negedge E);
        check_value("bus in reset", 0, bus, 10'h000);
        check_value("lcd_en in reset", 0, {9'd0, lcd_en}, 10'h000);
        @(posedge E);
        rst <= 1'b1;
        @(negedge E);
        check_value("bus after reset", 0, bus, 10'h000);
        check_value("lcd_en after reset", 0, {9'd0, lcd_en}, 10'h000);

        for (int f = 0; f < FRAMES; f++) begin
            for (int w = 0; w < FRAME_WORDS; w++) begin
                wait_word();
                sampled = bus;
                check_value($sformatf("frame %0d", f), w, sampled, frame_exp[w]);
                if (w == 4) begin
                    // new settings, latched before the first character
                    draw_panel(f, 1'b1, next_panel);
                    @(posedge E);
                    panel <= next_panel;
                    build_frame(next_panel);
                end else if (w == 20) begin
                    // mid-frame change, must not show this frame
                    draw_panel(f, 1'b0, next_panel);
                    @(posedge E);
                    panel <= next_panel;
                end
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* lcd_ctrl/lcd_bus_timer.sv */
//########################################
// slot timer for the LCD bus: step strobe
// once per slot, enable high for the first
// half of each slot
//########################################
`timescale 1ns/1ps

module lcd_bus_timer #(
    parameter int E_PERIOD = 16
) (
    input  logic E,
    input  logic rst,
    output logic step,
    output logic lcd_en
);

    localparam int CW = $clog2(E_PERIOD);
    localparam logic [CW-1:0] LAST = CW'(E_PERIOD - 1);
    // count value in the last high cycle of lcd_en
    localparam logic [CW-1:0] HALF = CW'(E_PERIOD / 2 - 1);

    logic [CW-1:0] cnt;

    // free-running down-counter, reloads on zero
    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            cnt <= LAST;
        end else if (cnt == '0) begin
            cnt <= LAST;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // strobe in the cycle after the wrap
    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            step <= 1'b0;
        end else begin
            step <= (cnt == '0);
        end
    end

    // rises with the new bus word, falls mid-slot
    // so the display samples a settled word
    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            lcd_en <= 1'b0;
        end else if (step) begin
            lcd_en <= 1'b1;
        end else if (cnt == HALF) begin
            lcd_en <= 1'b0;
        end
    end

endmodule

/* lcd_ctrl/lcd_sequencer.sv */
//########################################
// frame FSM of the LCD panel: nine setup
// commands, 64 character writes split over
// two DDRAM rows, then return home
//########################################
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_sequencer (
    input  logic             E,
    input  logic             rst,
    input  logic             step,
    input  lcd_pkg::char_t   char_code,
    output logic [5:0]       char_index,
    output logic             latch,
    output lcd_pkg::lcd_bus_t bus
);

    lcd_pkg::lcd_state_t state;

    // command word, rs low
    function automatic lcd_pkg::lcd_bus_t cmd_word(input lcd_pkg::lcd_cmd_t cmd);
        lcd_pkg::lcd_bus_t w;
        w.rs   = 1'b0;
        w.rw   = 1'b0;
        w.data = cmd;
        return w;
    endfunction

    // data word, rs high
    function automatic lcd_pkg::lcd_bus_t char_word(input lcd_pkg::char_t code);
        lcd_pkg::lcd_bus_t w;
        w.rs   = 1'b1;
        w.rw   = 1'b0;
        w.data = code;
        return w;
    endfunction

    // settings snapshot taken while the last setup word goes out,
    // so the composer is stable before the first character
    assign latch = step && (state == lcd_pkg::st_func);

    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            state      <= lcd_pkg::st_wake1;
            char_index <= '0;
            bus        <= '0;
        end else if (step) begin
            case (state)
                // wake-up sequence, same opcode three times
                lcd_pkg::st_wake1: begin
                    bus   <= cmd_word(lcd_pkg::wake_set);
                    state <= lcd_pkg::st_wake2;
                end
                lcd_pkg::st_wake2: begin
                    bus   <= cmd_word(lcd_pkg::wake_set);
                    state <= lcd_pkg::st_wake3;
                end
                lcd_pkg::st_wake3: begin
                    bus   <= cmd_word(lcd_pkg::wake_set);
                    state <= lcd_pkg::st_clear;
                end
                lcd_pkg::st_clear: begin
                    bus   <= cmd_word(lcd_pkg::clear);
                    state <= lcd_pkg::st_home;
                end
                lcd_pkg::st_home: begin
                    bus   <= cmd_word(lcd_pkg::home);
                    state <= lcd_pkg::st_entry;
                end
                lcd_pkg::st_entry: begin
                    bus   <= cmd_word(lcd_pkg::entry_mode);
                    state <= lcd_pkg::st_display;
                end
                lcd_pkg::st_display: begin
                    bus   <= cmd_word(lcd_pkg::display_on);
                    state <= lcd_pkg::st_shift;
                end
                lcd_pkg::st_shift: begin
                    bus   <= cmd_word(lcd_pkg::cursor_shift);
                    state <= lcd_pkg::st_func;
                end
                lcd_pkg::st_func: begin
                    bus   <= cmd_word(lcd_pkg::function_set);
                    state <= lcd_pkg::st_write_upper;
                end
                // first DDRAM row, lines 1 and 3
                lcd_pkg::st_write_upper: begin
                    bus        <= char_word(char_code);
                    char_index <= char_index + 6'd1;
                    if (char_index == 6'(`LCD_HALF_CHARS - 1)) begin
                        state <= lcd_pkg::st_jump_lower;
                    end
                end
                lcd_pkg::st_jump_lower: begin
                    bus   <= cmd_word(lcd_pkg::line2_addr);
                    state <= lcd_pkg::st_write_lower;
                end
                // second row, lines 2 and 4
                lcd_pkg::st_write_lower: begin
                    bus        <= char_word(char_code);
                    char_index <= char_index + 6'd1;
                    if (char_index == 6'(`LCD_CHARS - 1)) begin
                        state <= lcd_pkg::st_return_home;
                    end
                end
                lcd_pkg::st_return_home: begin
                    bus        <= cmd_word(lcd_pkg::home);
                    char_index <= '0;
                    state      <= lcd_pkg::st_wake1;
                end
                default: begin
                    state <= lcd_pkg::st_wake1;
                end
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the LCD panel testbench with Verilator
# exit status 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module lcd_panel_tb -o lcd_panel_sim > build.log 2>&1 \
    && ./obj_dir/lcd_panel_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error, see build.log and sim.log"

grep -q "Test completed successfully" sim.log 2>/dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

/* verilog.f */
+incdir+common
common/lcd_pkg.sv
common/panel_pkg.sv
lcd_ctrl/lcd_bus_timer.sv
lcd_ctrl/lcd_sequencer.sv
verilog/screen_composer.sv
verilog/lcd_panel_top.sv
dv/lcd_panel_assertions.sv
dv/lcd_panel_tb.sv

/* verilog/lcd_panel_top.sv */
//########################################
// LCD front panel of the LFO generator,
// drives an HD44780 4x16 display from the
// panel settings, frame repeats forever
//########################################
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_panel_top (
    input  logic              E,
    input  logic              rst,
    input  panel_pkg::panel_t panel,
    output lcd_pkg::lcd_bus_t bus,
    output logic              lcd_en
);

    logic           step;
    logic           latch;
    logic [5:0]     char_index;
    lcd_pkg::char_t char_code;

    // slot timing
    lcd_bus_timer #(
        .E_PERIOD (`LCD_E_PERIOD)
    ) lcd_bus_timer_i (
        .E      (E),
        .rst    (rst),
        .step   (step),
        .lcd_en (lcd_en)
    );

    // command and character sequence
    lcd_sequencer lcd_sequencer_i (
        .E          (E),
        .rst        (rst),
        .step       (step),
        .char_code  (char_code),
        .char_index (char_index),
        .latch      (latch),
        .bus        (bus)
    );

    // screen content lookup
    screen_composer screen_composer_i (
        .E          (E),
        .rst        (rst),
        .latch      (latch),
        .panel      (panel),
        .char_index (char_index),
        .char_code  (char_code)
    );

endmodule

/* verilog/screen_composer.sv */
//########################################
// holds the panel settings for one frame
// and returns the character code at any
// screen index, zero-cycle lookup
//########################################
`timescale 1ns/1ps
`include "lcd_consts.svh"

module screen_composer (
    input  logic              E,
    input  logic              rst,
    input  logic              latch,
    input  panel_pkg::panel_t panel,
    input  logic [5:0]        char_index,
    output lcd_pkg::char_t    char_code
);

    // static text pieces
    localparam logic [0:15][7:0] TITLE_TEXT = " LFO GENERATOR  ";
    localparam logic [0:6][7:0]  RATE_TEXT  = " RATE: ";
    localparam logic [0:4][7:0]  BPM_TEXT   = " BPM ";
    localparam logic [0:6][7:0]  WAVE_TEXT  = " WAVE: ";
    localparam logic [0:7][7:0]  DEPTH_TEXT = " DEPTH: ";

    panel_pkg::panel_t panel_q;

    lcd_pkg::char_t cur_rate;
    lcd_pkg::char_t cur_wave;
    lcd_pkg::char_t cur_depth;
    logic [0:7][7:0] name;
    logic [2:0] depth_lvl;
    lcd_pkg::char_t [0:4] bar;
    logic [9:0] bpm;
    logic [3:0] d_hund;
    logic [3:0] d_tens;
    logic [3:0] d_ones;
    lcd_pkg::char_t [0:2] digits;
    logic [0:`LCD_CHARS-1][7:0] screen;

    // name padded to 8 cells, unused codes show sine
    function automatic logic [0:7][7:0] wave_name(input panel_pkg::wave_t w);
        case (w)
            panel_pkg::square:      return "SQUARE  ";
            panel_pkg::triangle:    return "TRIANGLE";
            panel_pkg::ramp_up:     return "RAMP UP ";
            panel_pkg::ramp_down:   return "RAMPDOWN";
            panel_pkg::sample_hold: return "S & H   ";
            default:                return "SINE    ";
        endcase
    endfunction

    // one snapshot per frame
    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            panel_q <= '0;
        end else if (latch) begin
            panel_q <= panel;
        end
    end

    // cursor marks
    always_comb begin
        cur_rate  = `LCD_SPACE;
        cur_wave  = `LCD_SPACE;
        cur_depth = `LCD_SPACE;
        case (panel_q.sel)
            panel_pkg::sel_wave:  cur_wave  = `LCD_CURSOR_CHAR;
            panel_pkg::sel_depth: cur_depth = `LCD_CURSOR_CHAR;
            // sel_rate and sel_rate_alt
            default:              cur_rate  = `LCD_CURSOR_CHAR;
        endcase
    end

    assign name = wave_name(panel_q.wave);

    // depth bar, out of range levels show one block
    assign depth_lvl = (panel_q.depth > 3'd4) ? 3'd0 : panel_q.depth;

    always_comb begin
        for (int i = 0; i < 5; i++) begin
            bar[i] = (3'(i) <= depth_lvl) ? `LCD_BLOCK_CHAR : `LCD_SPACE;
        end
    end

    // bpm value, 30..800
    assign bpm = (panel_q.rate > 8'(`RATE_MAX)) ? 10'(`BPM_BASE)
               : 10'(`BPM_BASE + `BPM_STEP * int'(panel_q.rate));

    // decimal split
    assign d_hund = 4'(bpm / 10'd100);
    assign d_tens = 4'((bpm / 10'd10) % 10'd10);
    assign d_ones = 4'(bpm % 10'd10);

    // blank the hundreds digit when zero, tens is never leading
    assign digits[0] = (d_hund == 4'd0) ? `LCD_SPACE : (8'h30 + {4'h0, d_hund});
    assign digits[1] = 8'h30 + {4'h0, d_tens};
    assign digits[2] = 8'h30 + {4'h0, d_ones};

    // whole screen in index order
    assign screen = {TITLE_TEXT,
                     cur_rate, RATE_TEXT, digits, BPM_TEXT,
                     cur_wave, WAVE_TEXT, name,
                     cur_depth, DEPTH_TEXT, bar, `LCD_SPACE, `LCD_SPACE};

    assign char_code = screen[char_index];

endmodule
